// ==== Bender.yml ====
package:
  name: led_matrix

sources:
  - led_matrix_pkg.sv
  - led_command_ctrl.sv
  - frame_buffer.sv
  - matrix_scan.sv
  - led_matrix_top.sv
  - target: test
    files:
      - led_matrix_checks.sv
      - led_matrix_tb.sv

// ==== filelist.f ====
led_matrix_pkg.sv
led_command_ctrl.sv
frame_buffer.sv
matrix_scan.sv
led_matrix_top.sv
led_matrix_checks.sv
led_matrix_tb.sv

// ==== frame_buffer.sv ====
`timescale 1ns/100ps

module frame_buffer #(
    parameter int PIXEL_WIDTH  = led_matrix_pkg::default_pixel_width,
    parameter int PIXEL_HEIGHT = led_matrix_pkg::default_pixel_height
) (
    input  logic                             clk_in,
    input  logic                             wr_en,
    input  logic [$clog2(PIXEL_HEIGHT)-1:0]  wr_row,
    input  logic [$clog2(PIXEL_WIDTH)-1:0]   wr_col,
    input  logic                             wr_lane,
    input  logic [7:0]                       wr_byte,
    input  logic [$clog2(PIXEL_HEIGHT)-1:0]  rd_row,
    input  logic [$clog2(PIXEL_WIDTH)-1:0]   rd_col,
    output led_matrix_pkg::pixel_word_t      rd_word
);

    localparam int DEPTH     = PIXEL_WIDTH * PIXEL_HEIGHT;
    localparam int ADDR_BITS = $clog2(DEPTH);

    led_matrix_pkg::pixel_word_t mem [DEPTH];

    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] rd_addr;

    // row major layout
    assign wr_addr = ADDR_BITS'(wr_row * PIXEL_WIDTH + wr_col);
    assign rd_addr = ADDR_BITS'(rd_row * PIXEL_WIDTH + rd_col);

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0; // blank frame at power up
        end
    end

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr].byte_lane[wr_lane] <= wr_byte; // one lane, other kept
        end
        rd_word <= mem[rd_addr]; // same-cycle collision reads old word
    end

endmodule

// ==== led_command_ctrl.sv ====
`timescale 1ns/100ps

module led_command_ctrl #(
    parameter int PIXEL_WIDTH       = led_matrix_pkg::default_pixel_width,
    parameter int PIXEL_HEIGHT      = led_matrix_pkg::default_pixel_height,
    parameter int BRIGHTNESS_LEVELS = led_matrix_pkg::default_brightness_levels
) (
    input  logic                            clk_in,
    input  logic                            reset,
    input  logic [7:0]                      data_rx,
    input  logic                            data_valid,
    output logic [2:0]                      rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0]    brightness_enable,
    output logic                            wr_en,
    output logic [$clog2(PIXEL_HEIGHT)-1:0] wr_row,
    output logic [$clog2(PIXEL_WIDTH)-1:0]  wr_col,
    output logic                            wr_lane,
    output logic [7:0]                      wr_byte
);

    localparam int ROW_BITS  = $clog2(PIXEL_HEIGHT);
    localparam int COL_BITS  = $clog2(PIXEL_WIDTH);
    localparam int MAX_DIGIT = 6; // highest plane toggle digit

    typedef enum logic [2:0] {
        idle,
        read_brightness,
        row_addr,
        row_data,
        pixel_row,
        pixel_col,
        pixel_data
    } state_t;

    state_t               state;
    logic [ROW_BITS-1:0]  row_q;
    logic [COL_BITS-1:0]  col_q;
    logic                 lane_q;     // lane of the next pixel byte
    logic                 pixel_byte;
    logic                 last_col;

    assign pixel_byte = data_valid && (state == row_data || state == pixel_data);
    assign last_col   = (col_q == COL_BITS'(PIXEL_WIDTH - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= idle;
            rgb_enable        <= 3'b111;
            brightness_enable <= {BRIGHTNESS_LEVELS{1'b1}};
            wr_en             <= 1'b0;
            row_q             <= '0;
            col_q             <= '0;
            lane_q            <= 1'b1;
        end else begin
            wr_en <= pixel_byte; // every pixel byte is its own write
            if (data_valid) begin
                case (state)
                    idle: begin
                        case (data_rx)
                            led_matrix_pkg::cmd_red_on:         rgb_enable[0] <= 1'b1;
                            led_matrix_pkg::cmd_red_off:        rgb_enable[0] <= 1'b0;
                            led_matrix_pkg::cmd_green_on:       rgb_enable[1] <= 1'b1;
                            led_matrix_pkg::cmd_green_off:      rgb_enable[1] <= 1'b0;
                            led_matrix_pkg::cmd_blue_on:        rgb_enable[2] <= 1'b1;
                            led_matrix_pkg::cmd_blue_off:       rgb_enable[2] <= 1'b0;
                            led_matrix_pkg::cmd_all_planes_off: begin
                                brightness_enable <= '0;
                            end
                            led_matrix_pkg::cmd_all_planes_on: begin
                                brightness_enable <= {BRIGHTNESS_LEVELS{1'b1}};
                            end
                            led_matrix_pkg::cmd_set_brightness: state <= read_brightness;
                            led_matrix_pkg::cmd_write_row:      state <= row_addr;
                            led_matrix_pkg::cmd_write_pixel:    state <= pixel_row;
                            default: begin
                                // digit k flips plane BRIGHTNESS_LEVELS-k, others ignored
                                for (int i = 0; i < BRIGHTNESS_LEVELS; i++) begin
                                    if ((BRIGHTNESS_LEVELS - i) <= MAX_DIGIT &&
                                        data_rx == led_matrix_pkg::cmd_all_planes_off +
                                                   8'(BRIGHTNESS_LEVELS - i)) begin
                                        brightness_enable[i] <= ~brightness_enable[i];
                                    end
                                end
                            end
                        endcase
                    end
                    read_brightness: begin
                        brightness_enable <= data_rx[BRIGHTNESS_LEVELS-1:0];
                        state             <= idle;
                    end
                    row_addr: begin
                        row_q  <= data_rx[ROW_BITS-1:0]; // wraps through low bits
                        col_q  <= '0;
                        lane_q <= 1'b1;
                        state  <= row_data;
                    end
                    row_data: begin
                        lane_q <= ~lane_q;
                        if (!lane_q) begin
                            col_q <= col_q + 1'b1;
                            if (last_col) begin
                                state <= idle;
                            end
                        end
                    end
                    pixel_row: begin
                        row_q <= data_rx[ROW_BITS-1:0];
                        state <= pixel_col;
                    end
                    pixel_col: begin
                        col_q  <= data_rx[COL_BITS-1:0];
                        lane_q <= 1'b1;
                        state  <= pixel_data;
                    end
                    pixel_data: begin
                        lane_q <= ~lane_q;
                        if (!lane_q) begin
                            state <= idle; // low byte closes the pixel
                        end
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // write port payload
    always_ff @(posedge clk_in) begin
        if (pixel_byte) begin
            wr_row  <= row_q;
            wr_col  <= col_q;
            wr_lane <= lane_q;
            wr_byte <= data_rx;
        end
    end

endmodule

// ==== led_matrix_checks.sv ====
`timescale 1ns/100ps

module led_matrix_checks #(
    parameter int PIXEL_WIDTH       = led_matrix_pkg::default_pixel_width,
    parameter int PIXEL_HEIGHT      = led_matrix_pkg::default_pixel_height,
    parameter int BRIGHTNESS_LEVELS = led_matrix_pkg::default_brightness_levels,
    parameter int HOLD_OFF          = 4
) (
    input  logic                                 clk_in,
    input  logic [2:0]                           rgb_enable,
    input  logic [BRIGHTNESS_LEVELS-1:0]         brightness_enable,
    input  logic                                 scan_valid,
    input  logic [$clog2(BRIGHTNESS_LEVELS)-1:0] scan_plane,
    input  logic [$clog2(PIXEL_HEIGHT)-1:0]      scan_row,
    input  logic [$clog2(PIXEL_WIDTH)-1:0]       scan_col,
    input  logic                                 red_bit,
    input  logic                                 green_bit,
    input  logic                                 blue_bit,
    output int                                   checked
);

    // rgb565 field positions within the word
    localparam int red_lsb   = 11;
    localparam int green_lsb = 5;
    localparam int blue_lsb  = 0;

    int exp_plane = 0; // next expected scan position
    int exp_row   = 0;
    int exp_col   = 0;
    bit streaming = 1'b0; // scanner never stalls once running

    initial checked = 0;

    // model runs ahead of the DUT by a few cycles
    function automatic logic regs_settled();
        return (led_matrix_tb.cycle_count - led_matrix_tb.reg_stamp) > HOLD_OFF;
    endfunction

    function automatic logic pixel_settled();
        int stamp;
        stamp = led_matrix_tb.pixel_stamp[scan_row][scan_col];
        return scan_valid && regs_settled() && (led_matrix_tb.cycle_count - stamp) > HOLD_OFF;
    endfunction

    // msb-aligned plane bit of one channel field
    function automatic logic expected_bit(input int field_lsb, input int field_width,
                                          input int channel);
        logic [15:0] word;
        int          plane;
        word  = led_matrix_tb.frame[scan_row][scan_col];
        plane = int'(scan_plane);
        return word[field_lsb + field_width - BRIGHTNESS_LEVELS + plane] &
               led_matrix_tb.model_rgb[channel] & led_matrix_tb.model_mask[plane];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        led_matrix_tb.abort_run($sformatf(
            "[FAIL] time %0t: %s expected %0h, got %0h (plane %0d row %0d col %0d)",
            $time, name, expected, actual, scan_plane, scan_row, scan_col));
    endtask

    always @(negedge clk_in) begin
        if (pixel_settled()) begin
            checked <= checked + 1;
        end
    end

    always @(negedge clk_in) begin
        if (regs_settled()) begin
            assert (rgb_enable === led_matrix_tb.model_rgb)
            else report_mismatch("rgb_enable", led_matrix_tb.model_rgb, rgb_enable);
        end
    end

    always @(negedge clk_in) begin
        if (regs_settled()) begin
            assert (brightness_enable === led_matrix_tb.model_mask)
            else report_mismatch("brightness_enable", led_matrix_tb.model_mask,
                                 brightness_enable);
        end
    end

    // scan walks column, then row, then plane
    always @(negedge clk_in) begin
        if (streaming) begin
            assert (scan_valid === 1'b1)
            else report_mismatch("scan_valid", 1'b1, scan_valid);
        end
        if (scan_valid === 1'b1) begin
            assert (scan_plane == exp_plane)
            else report_mismatch("scan_plane", exp_plane, scan_plane);
            assert (scan_row == exp_row)
            else report_mismatch("scan_row", exp_row, scan_row);
            assert (scan_col == exp_col)
            else report_mismatch("scan_col", exp_col, scan_col);
            streaming = 1'b1;
            exp_col   = int'(scan_col) + 1;
            exp_row   = int'(scan_row);
            exp_plane = int'(scan_plane);
            if (exp_col == PIXEL_WIDTH) begin
                exp_col = 0;
                exp_row++;
            end
            if (exp_row == PIXEL_HEIGHT) begin
                exp_row   = 0;
                exp_plane = (exp_plane + 1) % BRIGHTNESS_LEVELS;
            end
        end
    end

    always @(negedge clk_in) begin
        if (pixel_settled()) begin
            assert (red_bit === expected_bit(red_lsb, 5, 0))
            else report_mismatch("red_bit", expected_bit(red_lsb, 5, 0), red_bit);
        end
    end

    always @(negedge clk_in) begin
        if (pixel_settled()) begin
            assert (green_bit === expected_bit(green_lsb, 6, 1))
            else report_mismatch("green_bit", expected_bit(green_lsb, 6, 1), green_bit);
        end
    end

    always @(negedge clk_in) begin
        if (pixel_settled()) begin
            assert (blue_bit === expected_bit(blue_lsb, 5, 2))
            else report_mismatch("blue_bit", expected_bit(blue_lsb, 5, 2), blue_bit);
        end
    end

endmodule

// ==== led_matrix_pkg.sv ====
package led_matrix_pkg;

    // matrix geometry defaults
    localparam int default_pixel_width       = 16;
    localparam int default_pixel_height      = 8;
    localparam int default_brightness_levels = 5;

    // command bytes from the serial link
    localparam logic [7:0] cmd_red_on         = "R";
    localparam logic [7:0] cmd_red_off        = "r";
    localparam logic [7:0] cmd_green_on       = "G";
    localparam logic [7:0] cmd_green_off      = "g";
    localparam logic [7:0] cmd_blue_on        = "B";
    localparam logic [7:0] cmd_blue_off       = "b";
    localparam logic [7:0] cmd_all_planes_off = "0"; // also the base for digit toggles
    localparam logic [7:0] cmd_all_planes_on  = "9";
    localparam logic [7:0] cmd_set_brightness = "T";
    localparam logic [7:0] cmd_write_row      = "L";
    localparam logic [7:0] cmd_write_pixel    = "P";

    // rgb565 field widths
    localparam int red_bits   = 5;
    localparam int green_bits = 6;
    localparam int blue_bits  = 5;

    typedef struct packed {
        logic [red_bits-1:0]   red;   // bits 15:11
        logic [green_bits-1:0] green;
        logic [blue_bits-1:0]  blue;  // bits 4:0
    } rgb565_t;

    // one stored pixel, seen as two bytes or as colour fields
    typedef union packed {
        logic [1:0][7:0] byte_lane; // lane 1 is the high byte
        rgb565_t         rgb;
    } pixel_word_t;

endpackage

// ==== led_matrix_tb.sv ====
`timescale 1ns/100ps

module led_matrix_tb;

    localparam int pixel_width       = led_matrix_pkg::default_pixel_width;
    localparam int pixel_height      = led_matrix_pkg::default_pixel_height;
    localparam int brightness_levels = led_matrix_pkg::default_brightness_levels;
    localparam int hold_off          = 4;
    localparam int frame_cycles      = pixel_width * pixel_height * brightness_levels;

    typedef enum {m_idle, m_mask, m_row_sel, m_row_bytes, m_pix_row, m_pix_col, m_pix_bytes}
        model_state_t;

    logic                                 clk_in;
    logic                                 reset;
    logic [7:0]                           data_rx;
    logic                                 data_valid;
    logic [2:0]                           rgb_enable;
    logic [brightness_levels-1:0]         brightness_enable;
    logic                                 scan_valid;
    logic [$clog2(brightness_levels)-1:0] scan_plane;
    logic [$clog2(pixel_height)-1:0]      scan_row;
    logic [$clog2(pixel_width)-1:0]       scan_col;
    logic                                 red_bit;
    logic                                 green_bit;
    logic                                 blue_bit;
    int                                   checked_count;

    // reference model
    logic [15:0]                  frame [pixel_height][pixel_width];
    int                           pixel_stamp [pixel_height][pixel_width];
    logic [2:0]                   model_rgb  = 3'b111;
    logic [brightness_levels-1:0] model_mask = '1;
    model_state_t                 mstate     = m_idle;
    int                           model_row;
    int                           model_col;
    bit                           model_high;
    int                           reg_stamp       = 0;
    int                           last_byte_stamp = 0;
    int                           cycle_count     = 0;

    led_matrix_top #(
        .PIXEL_WIDTH       (pixel_width),
        .PIXEL_HEIGHT      (pixel_height),
        .BRIGHTNESS_LEVELS (brightness_levels)
    ) UUT (
        .clk_in (clk_in), .reset (reset), .data_rx (data_rx), .data_valid (data_valid),
        .rgb_enable (rgb_enable), .brightness_enable (brightness_enable),
        .scan_valid (scan_valid), .scan_plane (scan_plane), .scan_row (scan_row),
        .scan_col (scan_col), .red_bit (red_bit), .green_bit (green_bit), .blue_bit (blue_bit)
    );

    led_matrix_checks #(
        .PIXEL_WIDTH       (pixel_width),
        .PIXEL_HEIGHT      (pixel_height),
        .BRIGHTNESS_LEVELS (brightness_levels),
        .HOLD_OFF          (hold_off)
    ) u_checks (
        .clk_in (clk_in), .rgb_enable (rgb_enable), .brightness_enable (brightness_enable),
        .scan_valid (scan_valid), .scan_plane (scan_plane), .scan_row (scan_row),
        .scan_col (scan_col), .red_bit (red_bit), .green_bit (green_bit),
        .blue_bit (blue_bit), .checked (checked_count)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    always @(posedge clk_in) cycle_count <= cycle_count + 1;

    initial begin
        for (int r = 0; r < pixel_height; r++) begin
            for (int c = 0; c < pixel_width; c++) begin
                frame[r][c]       = '0;
                pixel_stamp[r][c] = 0;
            end
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // decode one byte the way the command set defines it
    task automatic model_byte(input logic [7:0] b);
        int k;
        last_byte_stamp = cycle_count;
        case (mstate)
            m_idle: begin
                reg_stamp = cycle_count;
                case (b)
                    led_matrix_pkg::cmd_red_on:         model_rgb[0] = 1'b1;
                    led_matrix_pkg::cmd_red_off:        model_rgb[0] = 1'b0;
                    led_matrix_pkg::cmd_green_on:       model_rgb[1] = 1'b1;
                    led_matrix_pkg::cmd_green_off:      model_rgb[1] = 1'b0;
                    led_matrix_pkg::cmd_blue_on:        model_rgb[2] = 1'b1;
                    led_matrix_pkg::cmd_blue_off:       model_rgb[2] = 1'b0;
                    led_matrix_pkg::cmd_all_planes_off: model_mask = '0;
                    led_matrix_pkg::cmd_all_planes_on:  model_mask = '1;
                    led_matrix_pkg::cmd_set_brightness: mstate = m_mask;
                    led_matrix_pkg::cmd_write_row:      mstate = m_row_sel;
                    led_matrix_pkg::cmd_write_pixel:    mstate = m_pix_row;
                    default: begin
                        if (b >= "1" && b <= "6") begin
                            k = b - led_matrix_pkg::cmd_all_planes_off;
                            if (k <= brightness_levels) begin
                                model_mask[brightness_levels - k] =
                                    ~model_mask[brightness_levels - k];
                            end
                        end
                    end
                endcase
            end
            m_mask: begin
                model_mask = b[brightness_levels-1:0];
                reg_stamp  = cycle_count;
                mstate     = m_idle;
            end
            m_row_sel: begin
                model_row  = b % pixel_height;
                model_col  = 0;
                model_high = 1'b1;
                mstate     = m_row_bytes;
            end
            m_pix_row: begin
                model_row = b % pixel_height;
                mstate    = m_pix_col;
            end
            m_pix_col: begin
                model_col  = b % pixel_width;
                model_high = 1'b1;
                mstate     = m_pix_bytes;
            end
            default: begin // pixel bytes, high then low
                if (model_high) begin
                    frame[model_row][model_col][15:8] = b;
                end else begin
                    frame[model_row][model_col][7:0] = b;
                end
                pixel_stamp[model_row][model_col] = cycle_count;
                if (!model_high) begin
                    if (mstate == m_pix_bytes || model_col == pixel_width - 1) begin
                        mstate = m_idle;
                    end
                    model_col++;
                end
                model_high = !model_high;
            end
        endcase
    endtask

    task automatic send_byte(input logic [7:0] b, input bit spaced);
        int gap;
        gap = spaced ? $urandom_range(3, 0) : 0;
        repeat (gap) begin
            @(posedge clk_in);
            data_valid <= 1'b0;
        end
        @(posedge clk_in);
        data_rx    <= b;
        data_valid <= 1'b1;
        model_byte(b);
    endtask

    task automatic send_pixel(input logic [7:0] row, input logic [7:0] col,
                              input logic [15:0] word, input bit spaced);
        send_byte(led_matrix_pkg::cmd_write_pixel, spaced);
        send_byte(row, spaced);
        send_byte(col, spaced);
        send_byte(word[15:8], spaced);
        send_byte(word[7:0], spaced);
    endtask

    task automatic send_row(input logic [7:0] row, input bit spaced);
        send_byte(led_matrix_pkg::cmd_write_row, spaced);
        send_byte(row, spaced);
        repeat (2 * pixel_width) send_byte(8'($urandom), spaced);
    endtask

    // idle the link, then let one whole frame scan past the settled model
    task automatic wait_frame();
        int waited;
        bit seen_start;
        bit done;
        @(posedge clk_in);
        data_valid <= 1'b0;
        waited     = 0;
        seen_start = 1'b0;
        done       = 1'b0;
        while (!done) begin
            @(negedge clk_in);
            waited++;
            if (seen_start && scan_valid && scan_plane == brightness_levels - 1 &&
                scan_row == pixel_height - 1 && scan_col == pixel_width - 1) begin
                done = 1'b1;
            end
            if (scan_valid && scan_plane == 0 && scan_row == 0 && scan_col == 0 &&
                cycle_count - last_byte_stamp > hold_off) begin
                seen_start = 1'b1;
            end
            if (!done && waited > 3 * frame_cycles) begin
                abort_run("timed out waiting for a full scan frame");
            end
        end
    endtask

    initial begin
        void'($urandom(32'ha930_097f));
        reset      = 1'b1;
        data_rx    = '0;
        data_valid = 1'b0;
        repeat (2) @(posedge clk_in);
        reset <= 1'b0;
        wait_frame(); // blank frame, enables at reset value

        repeat (6) send_pixel(8'($urandom), 8'($urandom), 16'($urandom), 1'b1);
        wait_frame();
        send_row(8'($urandom), 1'b1);
        wait_frame();

        send_byte(led_matrix_pkg::cmd_red_off, 1'b1);
        wait_frame();
        send_byte(led_matrix_pkg::cmd_red_on, 1'b1);
        send_byte(led_matrix_pkg::cmd_green_off, 1'b1);
        wait_frame();
        send_byte(led_matrix_pkg::cmd_green_on, 1'b1);
        send_byte(led_matrix_pkg::cmd_blue_off, 1'b1);
        wait_frame();
        send_byte(led_matrix_pkg::cmd_blue_on, 1'b1);
        wait_frame();

        repeat (3) begin
            repeat (2) send_byte(8'(led_matrix_pkg::cmd_all_planes_off +
                                    $urandom_range(6, 1)), 1'b1);
            wait_frame();
            send_byte(led_matrix_pkg::cmd_set_brightness, 1'b1);
            send_byte(8'($urandom), 1'b1);
            wait_frame();
        end
        send_byte(led_matrix_pkg::cmd_all_planes_off, 1'b1);
        wait_frame();
        send_byte(led_matrix_pkg::cmd_all_planes_on, 1'b1);
        wait_frame();

        // bytes outside the command set
        send_byte("x", 1'b1);
        send_byte(8'hff, 1'b1);
        send_byte("7", 1'b1);
        send_byte("8", 1'b1);
        wait_frame();

        // same commands with no idle cycles between bytes
        send_byte(led_matrix_pkg::cmd_green_off, 1'b0);
        send_pixel(8'($urandom), 8'($urandom), 16'($urandom), 1'b0);
        send_row(8'($urandom), 1'b0);
        send_byte("3", 1'b0);
        send_byte(led_matrix_pkg::cmd_green_on, 1'b0);
        wait_frame();

        if (checked_count > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("no scan output was ever compared with the model");
        end
    end

endmodule

// ==== led_matrix_top.sv ====
`timescale 1ns/100ps

module led_matrix_top #(
    parameter int PIXEL_WIDTH       = led_matrix_pkg::default_pixel_width,
    parameter int PIXEL_HEIGHT      = led_matrix_pkg::default_pixel_height,
    parameter int BRIGHTNESS_LEVELS = led_matrix_pkg::default_brightness_levels
) (
    input  logic                                 clk_in,
    input  logic                                 reset,
    input  logic [7:0]                           data_rx,
    input  logic                                 data_valid,
    output logic [2:0]                           rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0]         brightness_enable,
    output logic                                 scan_valid,
    output logic [$clog2(BRIGHTNESS_LEVELS)-1:0] scan_plane,
    output logic [$clog2(PIXEL_HEIGHT)-1:0]      scan_row,
    output logic [$clog2(PIXEL_WIDTH)-1:0]       scan_col,
    output logic                                 red_bit,
    output logic                                 green_bit,
    output logic                                 blue_bit
);

    // write side
    logic                            wr_en;
    logic [$clog2(PIXEL_HEIGHT)-1:0] wr_row;
    logic [$clog2(PIXEL_WIDTH)-1:0]  wr_col;
    logic                            wr_lane;
    logic [7:0]                      wr_byte;

    // read side
    logic [$clog2(PIXEL_HEIGHT)-1:0] rd_row;
    logic [$clog2(PIXEL_WIDTH)-1:0]  rd_col;
    led_matrix_pkg::pixel_word_t     rd_word;

    led_command_ctrl #(
        .PIXEL_WIDTH       (PIXEL_WIDTH),
        .PIXEL_HEIGHT      (PIXEL_HEIGHT),
        .BRIGHTNESS_LEVELS (BRIGHTNESS_LEVELS)
    ) u_ctrl (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_valid        (data_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .wr_en             (wr_en),
        .wr_row            (wr_row),
        .wr_col            (wr_col),
        .wr_lane           (wr_lane),
        .wr_byte           (wr_byte)
    );

    frame_buffer #(
        .PIXEL_WIDTH  (PIXEL_WIDTH),
        .PIXEL_HEIGHT (PIXEL_HEIGHT)
    ) u_buffer (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_row  (wr_row),
        .wr_col  (wr_col),
        .wr_lane (wr_lane),
        .wr_byte (wr_byte),
        .rd_row  (rd_row),
        .rd_col  (rd_col),
        .rd_word (rd_word)
    );

    matrix_scan #(
        .PIXEL_WIDTH       (PIXEL_WIDTH),
        .PIXEL_HEIGHT      (PIXEL_HEIGHT),
        .BRIGHTNESS_LEVELS (BRIGHTNESS_LEVELS)
    ) u_scan (
        .clk_in            (clk_in),
        .reset             (reset),
        .rgb_enable        (rgb_enable),        // scanner samples the live enables
        .brightness_enable (brightness_enable),
        .rd_word           (rd_word),
        .rd_row            (rd_row),
        .rd_col            (rd_col),
        .scan_valid        (scan_valid),
        .scan_plane        (scan_plane),
        .scan_row          (scan_row),
        .scan_col          (scan_col),
        .red_bit           (red_bit),
        .green_bit         (green_bit),
        .blue_bit          (blue_bit)
    );

endmodule

// ==== matrix_scan.sv ====
`timescale 1ns/100ps

module matrix_scan #(
    parameter int PIXEL_WIDTH       = led_matrix_pkg::default_pixel_width,
    parameter int PIXEL_HEIGHT      = led_matrix_pkg::default_pixel_height,
    parameter int BRIGHTNESS_LEVELS = led_matrix_pkg::default_brightness_levels
) (
    input  logic                                 clk_in,
    input  logic                                 reset,
    input  logic [2:0]                           rgb_enable,
    input  logic [BRIGHTNESS_LEVELS-1:0]         brightness_enable,
    input  led_matrix_pkg::pixel_word_t          rd_word,
    output logic [$clog2(PIXEL_HEIGHT)-1:0]      rd_row,
    output logic [$clog2(PIXEL_WIDTH)-1:0]       rd_col,
    output logic                                 scan_valid,
    output logic [$clog2(BRIGHTNESS_LEVELS)-1:0] scan_plane,
    output logic [$clog2(PIXEL_HEIGHT)-1:0]      scan_row,
    output logic [$clog2(PIXEL_WIDTH)-1:0]       scan_col,
    output logic                                 red_bit,
    output logic                                 green_bit,
    output logic                                 blue_bit
);

    localparam int PLANE_BITS = $clog2(BRIGHTNESS_LEVELS);
    localparam int ROW_BITS   = $clog2(PIXEL_HEIGHT);
    localparam int COL_BITS   = $clog2(PIXEL_WIDTH);

    // lowest field bit shown on plane 0
    localparam int RED_BASE   = led_matrix_pkg::red_bits - BRIGHTNESS_LEVELS;
    localparam int GREEN_BASE = led_matrix_pkg::green_bits - BRIGHTNESS_LEVELS;
    localparam int BLUE_BASE  = led_matrix_pkg::blue_bits - BRIGHTNESS_LEVELS;

    logic [PLANE_BITS-1:0] plane_q; // address stage, with rd_row/rd_col
    logic                  data_valid_q;
    logic [PLANE_BITS-1:0] data_plane;
    logic [ROW_BITS-1:0]   data_row;
    logic [COL_BITS-1:0]   data_col;
    logic                  last_col;
    logic                  last_row;
    logic                  last_plane;
    logic                  plane_on;

    assign last_col   = (rd_col == COL_BITS'(PIXEL_WIDTH - 1));
    assign last_row   = (rd_row == ROW_BITS'(PIXEL_HEIGHT - 1));
    assign last_plane = (plane_q == PLANE_BITS'(BRIGHTNESS_LEVELS - 1));
    assign plane_on   = brightness_enable[data_plane];

    // column, then row, then plane
    always_ff @(posedge clk_in) begin
        if (reset) begin
            plane_q <= '0;
            rd_row  <= '0;
            rd_col  <= '0;
        end else begin
            rd_col <= last_col ? '0 : rd_col + 1'b1;
            if (last_col) begin
                rd_row <= last_row ? '0 : rd_row + 1'b1;
                if (last_row) begin
                    plane_q <= last_plane ? '0 : plane_q + 1'b1;
                end
            end
        end
    end

    // data stage lines up with rd_word
    always_ff @(posedge clk_in) begin
        if (reset) begin
            data_valid_q <= 1'b0;
            data_plane   <= '0;
            data_row     <= '0;
            data_col     <= '0;
        end else begin
            data_valid_q <= 1'b1;
            data_plane   <= plane_q;
            data_row     <= rd_row;
            data_col     <= rd_col;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            scan_valid <= 1'b0;
            scan_plane <= '0;
            scan_row   <= '0;
            scan_col   <= '0;
            red_bit    <= 1'b0;
            green_bit  <= 1'b0;
            blue_bit   <= 1'b0;
        end else begin
            scan_valid <= data_valid_q;
            scan_plane <= data_plane;
            scan_row   <= data_row;
            scan_col   <= data_col;
            red_bit    <= rd_word.rgb.red[RED_BASE + data_plane] & rgb_enable[0] & plane_on;
            green_bit  <= rd_word.rgb.green[GREEN_BASE + data_plane] & rgb_enable[1] &
                          plane_on;
            blue_bit   <= rd_word.rgb.blue[BLUE_BASE + data_plane] & rgb_enable[2] & plane_on;
        end
    end

endmodule
